//--- tb.f
+incdir+dv
src/fsense_pkg.sv
src/lms_fir.sv
src/haar_dwt.sv
src/band_power.sv
src/peak_encoder.sv
src/field_sensor_core.sv
dv/tb_field_sensor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the field sensor core testbench with Verilator.
# Exits non-zero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_field_sensor

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- dv/tb_ref_model.svh
// Reference model for the field sensor core testbench
// Behavioral FIR, Haar lifting, band power and peak pick. The FIR history
// lives in the testbench scope so it carries from one frame to the next

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

sample_t ref_hist [8];
sample_t ref_blk  [8];
int      ref_fill;

function automatic void reset_model();
    for (int i = 0; i < 8; i++) begin
        ref_hist[i] = '0;
        ref_blk[i]  = '0;
    end
    ref_fill = 0;
endfunction

// Newest sample sits at tap 0 and each tap is scaled by its right shift
function automatic sample_t filter_sample(adc_t s);
    int acc;
    for (int i = 7; i > 0; i--) begin
        ref_hist[i] = ref_hist[i-1];
    end
    ref_hist[0] = sample_t'(s);
    acc = 0;
    for (int i = 0; i < 8; i++) begin
        acc = acc + (int'(ref_hist[i]) >>> FIR_SHIFTS[i]);
    end
    return sample_t'(acc);
endfunction

// Three lifting levels with detail = odd - even and approx = even + detail / 2
function automatic subband_frame_t haar_transform(input sample_t blk [8]);
    coef_t          x  [8];
    coef_t          a1 [4];
    coef_t          d1 [4];
    coef_t          a2 [2];
    coef_t          d2 [2];
    coef_t          a3;
    coef_t          d3;
    subband_frame_t f;
    for (int i = 0; i < 8; i++) begin
        x[i] = coef_t'(blk[i]);
    end
    for (int i = 0; i < 4; i++) begin
        d1[i] = x[2*i+1] - x[2*i];
        a1[i] = x[2*i] + (d1[i] >>> 1);
    end
    for (int i = 0; i < 2; i++) begin
        d2[i] = a1[2*i+1] - a1[2*i];
        a2[i] = a1[2*i] + (d2[i] >>> 1);
    end
    d3 = a2[1] - a2[0];
    a3 = a2[0] + (d3 >>> 1);
    f.approx3   = a3;
    f.detail3   = d3;
    f.detail2_0 = d2[0];
    f.detail2_1 = d2[1];
    f.detail1_0 = d1[0];
    f.detail1_1 = d1[1];
    f.detail1_2 = d1[2];
    f.detail1_3 = d1[3];
    return f;
endfunction

// Top 16 bits of the 24-bit square of the magnitude
function automatic logic [POWER_W-1:0] square_power(coef_t c);
    int v;
    v = int'(c);
    if (v < 0) begin
        v = -v;
    end
    return POWER_W'((v * v) >>> 8);
endfunction

function automatic power_frame_t frame_power(subband_frame_t f);
    power_frame_t p;
    p.band0 = square_power(f.approx3);
    p.band1 = square_power(f.detail3);
    p.band2 = square_power(f.detail2_0);
    p.band3 = square_power(f.detail2_1);
    p.band4 = square_power(f.detail1_0);
    p.band5 = square_power(f.detail1_1);
    p.band6 = square_power(f.detail1_2);
    p.band7 = square_power(f.detail1_3);
    return p;
endfunction

// Strictly greater wins, so ties keep the lowest band
function automatic cmd_t pick_peak(power_frame_t p);
    logic [POWER_W-1:0] bands [8];
    cmd_t               best;
    bands = '{p.band0, p.band1, p.band2, p.band3,
              p.band4, p.band5, p.band6, p.band7};
    best  = '0;
    for (int i = 0; i < NUM_BANDS; i++) begin
        if (bands[i] > best.power) begin
            best.power = bands[i];
            best.index = CMD_W'(i);
        end
    end
    return best;
endfunction

// Returns 1 with the command when the sample completes a frame
function automatic bit take_model_sample(adc_t s, output cmd_t c);
    ref_blk[ref_fill] = filter_sample(s);
    ref_fill++;
    c = '0;
    if (ref_fill < NUM_BANDS) begin
        return 1'b0;
    end
    ref_fill = 0;
    c = pick_peak(frame_power(haar_transform(ref_blk)));
    return 1'b1;
endfunction

`endif

//--- dv/tb_field_sensor.sv
// Testbench for the field sensor core
// Sends ADC frames with random gaps and command back-pressure, and checks
// every command against the reference model in order

`timescale 1ns/1ps
`default_nettype none

module tb_field_sensor
    import fsense_pkg::*;
();

    localparam int RAND_FRAMES  = 40;
    localparam int STREAM_LEN   = RAND_FRAMES * NUM_BANDS;
    // Three directed frames, then a zero frame and the stream in each pass
    localparam int TOTAL_FRAMES = 3 + 2 * (RAND_FRAMES + 1);

    logic clk;
    logic rst_n;
    adc_t adc_data;
    logic adc_valid;
    logic adc_ready;
    cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;

    cmd_t exp_q [$];
    adc_t stream [STREAM_LEN];
    int   cycle_cnt;
    int   sent_cnt;
    int   cmd_cnt;
    logic ready_random;
    logic held_valid;
    cmd_t held_cmd;

    `include "tb_ref_model.svh"

    field_sensor_core field_sensor_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .adc_data  (adc_data),
        .adc_valid (adc_valid),
        .adc_ready (adc_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ======================================================================
    // Error handling and the compare task
    // ======================================================================
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Send one sample after an optional gap and hold it until the DUT takes it
    task automatic send_sample(adc_t s, int max_gap);
        int   gap;
        cmd_t c;
        gap = $urandom_range(max_gap, 0);
        repeat (gap) @(negedge clk);
        adc_valid = 1'b1;
        adc_data  = s;
        do begin
            @(posedge clk);
        end while (!adc_ready);
        @(negedge clk);
        adc_valid = 1'b0;
        adc_data  = '0;
        sent_cnt++;
        if (take_model_sample(s, c)) begin
            exp_q.push_back(c);
        end
    endtask

    task automatic send_frame_const(adc_t s);
        for (int i = 0; i < NUM_BANDS; i++) begin
            send_sample(s, 0);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Command back-pressure is random only in the last phase
    always @(negedge clk) begin
        if (ready_random) begin
            cmd_ready = 1'($urandom_range(1, 0));
        end else begin
            cmd_ready = 1'b1;
        end
    end

    // ======================================================================
    // Command monitor
    // ======================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            // A stalled command must stay put
            if (held_valid) begin
                check_value("cmd_valid", 32'(cmd_valid), 32'd1);
                check_value("cmd", 32'(cmd), 32'(held_cmd));
            end
            if (cmd_valid && cmd_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A command was sent when none was expected");
                    abort_run();
                end else begin
                    check_value("cmd", 32'(cmd), 32'(exp_q.pop_front()));
                    cmd_cnt++;
                end
            end
            held_valid = cmd_valid && !cmd_ready;
            held_cmd   = cmd;
        end
    end

    // Limit grows with the samples sent so far
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 40 * sent_cnt + 2000) begin
            $display("Timeout, no progress after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        void'($urandom(32'h7df));
        rst_n        = 1'b0;
        adc_valid    = 1'b0;
        adc_data     = '0;
        cmd_ready    = 1'b1;
        ready_random = 1'b0;
        held_valid   = 1'b0;
        held_cmd     = '0;
        cycle_cnt    = 0;
        sent_cnt     = 0;
        cmd_cnt      = 0;
        reset_model();

        // Outputs idle through reset and just after it
        repeat (8) begin
            @(negedge clk);
            check_value("cmd_valid", 32'(cmd_valid), 32'd0);
            check_value("adc_ready", 32'(adc_ready), 32'd1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("cmd_valid", 32'(cmd_valid), 32'd0);
        check_value("adc_ready", 32'(adc_ready), 32'd1);

        // Constant positive frame
        send_frame_const(4'sd5);
        wait_drain();

        // Most negative input followed by alternating extremes
        send_frame_const(-4'sd8);
        for (int i = 0; i < NUM_BANDS; i++) begin
            send_sample((i % 2 == 0) ? -4'sd8 : 4'sd7, 0);
        end
        wait_drain();

        for (int i = 0; i < STREAM_LEN; i++) begin
            stream[i] = adc_t'($urandom_range(15, 0));
        end

        // Zero frame clears the FIR history so both runs start alike
        send_frame_const(4'sd0);
        for (int i = 0; i < STREAM_LEN; i++) begin
            send_sample(stream[i], 3);
        end
        wait_drain();

        // Same stream under random command back-pressure
        ready_random = 1'b1;
        send_frame_const(4'sd0);
        for (int i = 0; i < STREAM_LEN; i++) begin
            send_sample(stream[i], 3);
        end

        // One command comes back for every frame sent
        while (cmd_cnt < TOTAL_FRAMES) begin
            @(negedge clk);
        end
        repeat (40) @(negedge clk);

        check_value("cmd_cnt", 32'(cmd_cnt), 32'(TOTAL_FRAMES));
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d commands never received", exp_q.size());
            abort_run();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src/field_sensor_core.sv
// Field sensor core top level
// ADC samples -> FIR -> Haar transform -> band power -> peak command
// Every link is a valid/ready handshake, so back-pressure on the command
// output stalls the stages upstream one after the other

`timescale 1ns/1ps
`default_nettype none

module field_sensor_core
    import fsense_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire adc_t adc_data,
    input  wire       adc_valid,
    output logic      adc_ready,
    output cmd_t      cmd,
    output logic      cmd_valid,
    input  wire       cmd_ready
);

    // ==================================================================
    // Inter-stage links
    // ==================================================================
    sample_t        fir_data;
    logic           fir_valid;
    logic           fir_ready;

    subband_frame_t dwt_frame;
    logic           dwt_valid;
    logic           dwt_ready;

    power_frame_t   pwr_frame;
    logic           pwr_valid;
    logic           pwr_ready;

    lms_fir lms_fir_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (adc_data),
        .in_valid  (adc_valid),
        .in_ready  (adc_ready),
        .out_data  (fir_data),
        .out_valid (fir_valid),
        .out_ready (fir_ready)
    );

    // Eight filtered samples make one frame
    haar_dwt haar_dwt_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (fir_data),
        .in_valid  (fir_valid),
        .in_ready  (fir_ready),
        .out_frame (dwt_frame),
        .out_valid (dwt_valid),
        .out_ready (dwt_ready)
    );

    band_power band_power_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_frame  (dwt_frame),
        .in_valid  (dwt_valid),
        .in_ready  (dwt_ready),
        .out_frame (pwr_frame),
        .out_valid (pwr_valid),
        .out_ready (pwr_ready)
    );

    peak_encoder peak_encoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_frame  (pwr_frame),
        .in_valid  (pwr_valid),
        .in_ready  (pwr_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

endmodule

`default_nettype wire

//--- src/peak_encoder.sv
// Peak band encoder
// Scans the band powers one per cycle and reports the strongest band with
// its power. Ties go to the lowest band index

`timescale 1ns/1ps
`default_nettype none

module peak_encoder
    import fsense_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire power_frame_t in_frame,
    input  wire               in_valid,
    output logic              in_ready,
    output cmd_t              cmd,
    output logic              cmd_valid,
    input  wire               cmd_ready
);

    localparam int CNT_W = CMD_W + 1;

    power_frame_t                      frame_q;
    logic [NUM_BANDS-1:0][POWER_W-1:0] power_view;
    logic [CNT_W-1:0]                  band_q;
    logic                              busy_q;
    logic                              take_in;
    logic                              last_band;
    logic [POWER_W-1:0]                cur_power;
    logic [POWER_W-1:0]                max_q;
    logic [CMD_W-1:0]                  max_idx_q;

    assign in_ready  = !busy_q && !cmd_valid;
    assign take_in   = in_valid && in_ready;
    assign last_band = (band_q == CNT_W'(NUM_BANDS));

    // Band 0 sits in the top element of the packed view
    assign power_view = frame_q;
    assign cur_power  = power_view[CMD_W'(NUM_BANDS - 1) - band_q[CMD_W-1:0]];

    // ==================================================================
    // Scan control
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            band_q    <= '0;
            cmd_valid <= 1'b0;
        end else begin
            if (take_in) begin
                busy_q <= 1'b1;
                band_q <= '0;
            end else if (busy_q) begin
                if (last_band) begin
                    busy_q    <= 1'b0;
                    cmd_valid <= 1'b1;
                end else begin
                    band_q <= band_q + 1'b1;
                end
            end
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    // Running maximum, only a strictly larger power takes over
    always_ff @(posedge clk) begin
        if (take_in) begin
            frame_q   <= in_frame;
            max_q     <= '0;
            max_idx_q <= '0;
        end else if (busy_q && !last_band && cur_power > max_q) begin
            max_q     <= cur_power;
            max_idx_q <= band_q[CMD_W-1:0];
        end
        if (busy_q && last_band) begin
            cmd <= '{index: max_idx_q, power: max_q};
        end
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

//--- src/band_power.sv
// Subband power stage
// Takes the magnitude of each coefficient and squares it on one shared
// multiplier, one band per cycle, keeping the top bits of the square

`timescale 1ns/1ps
`default_nettype none

module band_power
    import fsense_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire subband_frame_t in_frame,
    input  wire                 in_valid,
    output logic                in_ready,
    output power_frame_t        out_frame,
    output logic                out_valid,
    input  wire                 out_ready
);

    localparam int CNT_W = $clog2(NUM_BANDS) + 1;
    localparam int SQ_W  = 2 * COEF_W;

    subband_frame_t                    frame_q;
    // Packed views put band 0 in the top element
    coef_t [NUM_BANDS-1:0]             coef_view;
    logic  [NUM_BANDS-1:0][POWER_W-1:0] power_q;
    logic  [CNT_W-1:0]                 band_q;
    logic  [CNT_W-2:0]                 slot;
    logic                              busy_q;
    logic                              take_in;
    logic                              last_band;
    coef_t                             coef_sel;
    logic  [COEF_W-1:0]                mag;
    logic  [SQ_W-1:0]                  square;

    assign in_ready  = !busy_q && !out_valid;
    assign take_in   = in_valid && in_ready;
    assign last_band = (band_q == CNT_W'(NUM_BANDS));

    // Band select, magnitude and the shared square
    assign coef_view = frame_q;
    assign slot      = (CNT_W-1)'(NUM_BANDS - 1) - band_q[CNT_W-2:0];
    assign coef_sel  = coef_view[slot];
    // Most negative coefficient still fits as an unsigned magnitude
    assign mag       = coef_sel[COEF_W-1] ? (~coef_sel) + 1'b1 : coef_sel;
    assign square    = mag * mag;

    assign out_frame = power_frame_t'(power_q);

    // ==================================================================
    // Band sequencer
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            band_q    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (take_in) begin
                busy_q <= 1'b1;
                band_q <= '0;
            end else if (busy_q) begin
                if (last_band) begin
                    busy_q    <= 1'b0;
                    out_valid <= 1'b1;
                end else begin
                    band_q <= band_q + 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_in) begin
            frame_q <= in_frame;
        end
        if (busy_q && !last_band) begin
            power_q[slot] <= square[SQ_W-1 -: POWER_W];
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_frame));

endmodule

`default_nettype wire

//--- src/haar_dwt.sv
// Three-level Haar lifting transform
// Collects eight filtered samples, runs one lifting level per cycle and
// packs the eight subbands into a frame. The buffer refills while the
// finished frame waits downstream

`timescale 1ns/1ps
`default_nettype none

module haar_dwt
    import fsense_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire sample_t   in_data,
    input  wire            in_valid,
    output logic           in_ready,
    output subband_frame_t out_frame,
    output logic           out_valid,
    input  wire            out_ready
);

    localparam int PTR_W = $clog2(NUM_BANDS);

    coef_t            buf_q [NUM_BANDS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic             full_q;
    // 0 idle, 1..3 level done, output loads when leaving 3
    logic [1:0]       step_q;
    coef_t            l1_a_q [4];
    coef_t            l1_d_q [4];
    coef_t            l2_a_q [2];
    coef_t            l2_d_q [2];
    coef_t            l3_a_q;
    coef_t            l3_d_q;
    logic             take_in;
    logic             start_xform;
    coef_t            in_ext;

    // Haar pair, detail is odd minus even
    function automatic coef_t lift_detail(coef_t even, coef_t odd);
        return odd - even;
    endfunction

    // Approximation is even plus half the detail
    function automatic coef_t lift_approx(coef_t even, coef_t detail);
        return even + (detail >>> 1);
    endfunction

    assign in_ext = {{(COEF_W-SAMPLE_W){in_data[SAMPLE_W-1]}}, in_data};

    // Stall while lifting, or when a full buffer cannot be handed on
    assign in_ready    = (step_q == 2'd0) && !(full_q && out_valid);
    assign take_in     = in_valid && in_ready;
    assign start_xform = full_q && (step_q == 2'd0) && !out_valid;

    // ==================================================================
    // Fill pointer and lifting sequencer
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            full_q    <= 1'b0;
            step_q    <= 2'd0;
            out_valid <= 1'b0;
        end else begin
            if (take_in) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                if (wr_ptr_q == PTR_W'(NUM_BANDS - 1)) begin
                    full_q <= 1'b1;
                end
            end
            // Level 1 frees the buffer, slot 0 may refill on the same edge
            if (start_xform) begin
                full_q <= 1'b0;
                step_q <= 2'd1;
            end else if (step_q != 2'd0) begin
                step_q <= step_q + 2'd1;
            end
            if (step_q == 2'd3) begin
                out_valid <= 1'b1;
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Sample buffer, lifting levels and output frame
    // ==================================================================
    always_ff @(posedge clk) begin
        if (take_in) begin
            buf_q[wr_ptr_q] <= in_ext;
        end
        // Level 1, four pairs from the raw samples
        if (start_xform) begin
            for (int i = 0; i < 4; i++) begin
                l1_d_q[i] <= lift_detail(buf_q[2*i], buf_q[2*i+1]);
                l1_a_q[i] <= lift_approx(buf_q[2*i], lift_detail(buf_q[2*i], buf_q[2*i+1]));
            end
        end
        // Level 2, two pairs from the level-1 approximations
        if (step_q == 2'd1) begin
            for (int i = 0; i < 2; i++) begin
                l2_d_q[i] <= lift_detail(l1_a_q[2*i], l1_a_q[2*i+1]);
                l2_a_q[i] <= lift_approx(l1_a_q[2*i], lift_detail(l1_a_q[2*i], l1_a_q[2*i+1]));
            end
        end
        if (step_q == 2'd2) begin
            l3_d_q <= lift_detail(l2_a_q[0], l2_a_q[1]);
            l3_a_q <= lift_approx(l2_a_q[0], lift_detail(l2_a_q[0], l2_a_q[1]));
        end
        if (step_q == 2'd3) begin
            out_frame <= '{approx3:   l3_a_q,
                           detail3:   l3_d_q,
                           detail2_0: l2_d_q[0],
                           detail2_1: l2_d_q[1],
                           detail1_0: l1_d_q[0],
                           detail1_1: l1_d_q[1],
                           detail1_2: l1_d_q[2],
                           detail1_3: l1_d_q[3]};
        end
    end

    a_ptr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (step_q != 2'd0) |=> $stable(wr_ptr_q));

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_frame));

endmodule

`default_nettype wire

//--- src/lms_fir.sv
// Eight-tap shift-add FIR for the field sensor core
// Each accepted ADC sample enters the delay line, then the taps are summed
// serially, one per cycle, each scaled by its table shift

`timescale 1ns/1ps
`default_nettype none

module lms_fir
    import fsense_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire adc_t in_data,
    input  wire     in_valid,
    output logic    in_ready,
    output sample_t out_data,
    output logic    out_valid,
    input  wire     out_ready
);

    localparam int TAPS  = $size(FIR_SHIFTS);
    localparam int CNT_W = $clog2(TAPS) + 1;

    sample_t          delay_q [TAPS];
    sample_t          acc_q;
    logic [CNT_W-1:0] tap_q;
    logic             busy_q;
    logic             take_in;
    logic             last_tap;
    sample_t          in_ext;
    sample_t          term;

    // Sign-extend the raw sample to the filter width
    assign in_ext = {{(SAMPLE_W-ADC_BITS){in_data[ADC_BITS-1]}}, in_data};

    // Only one sample in flight, output must be drained first
    assign in_ready = !busy_q && !out_valid;
    assign take_in  = in_valid && in_ready;

    // Counter past the last tap means the sum is complete
    assign last_tap = (tap_q == CNT_W'(TAPS));

    // Arithmetic shift keeps negative taps negative
    assign term = delay_q[tap_q[CNT_W-2:0]] >>> FIR_SHIFTS[tap_q[CNT_W-2:0]];

    // ==================================================================
    // Control and delay line
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            tap_q     <= '0;
            out_valid <= 1'b0;
            for (int i = 0; i < TAPS; i++) begin
                delay_q[i] <= '0;
            end
        end else begin
            if (take_in) begin
                // History is kept across frames
                delay_q[0] <= in_ext;
                for (int i = 1; i < TAPS; i++) begin
                    delay_q[i] <= delay_q[i-1];
                end
                busy_q <= 1'b1;
                tap_q  <= '0;
            end else if (busy_q) begin
                if (last_tap) begin
                    busy_q    <= 1'b0;
                    out_valid <= 1'b1;
                end else begin
                    tap_q <= tap_q + 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Serial accumulator and output register
    always_ff @(posedge clk) begin
        if (take_in) begin
            acc_q <= '0;
        end else if (busy_q && !last_tap) begin
            acc_q <= acc_q + term;
        end
        if (busy_q && last_tap) begin
            out_data <= acc_q;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- src/fsense_pkg.sv
// Field sensor core shared definitions
// Sample widths, FIR tap weights and the frame and command payload types
// carried between the FIR, Haar transform, band power and peak stages

`default_nettype none

package fsense_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    localparam int ADC_BITS  = 4;
    localparam int SAMPLE_W  = 8;
    localparam int COEF_W    = 12;
    localparam int NUM_BANDS = 8;
    localparam int POWER_W   = 16;
    localparam int CMD_W     = 3;

    // Right shift per FIR tap, tap 0 is the newest sample
    // Weights sum to one: 1/4 + 1/8 + 4 * 1/16 + 1/8 + 1/4
    localparam int FIR_SHIFTS [8] = '{2, 3, 4, 4, 4, 4, 3, 2};

    // ==================================================================
    // Payload types
    // ==================================================================
    typedef logic signed [ADC_BITS-1:0] adc_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;

    // First field sits at the top of the vector
    typedef struct packed {
        coef_t approx3;
        coef_t detail3;
        coef_t detail2_0;
        coef_t detail2_1;
        coef_t detail1_0;
        coef_t detail1_1;
        coef_t detail1_2;
        coef_t detail1_3;
    } subband_frame_t;

    // Same band order as the subband frame
    typedef struct packed {
        logic [POWER_W-1:0] band0;
        logic [POWER_W-1:0] band1;
        logic [POWER_W-1:0] band2;
        logic [POWER_W-1:0] band3;
        logic [POWER_W-1:0] band4;
        logic [POWER_W-1:0] band5;
        logic [POWER_W-1:0] band6;
        logic [POWER_W-1:0] band7;
    } power_frame_t;

    typedef struct packed {
        logic [CMD_W-1:0]   index;
        logic [POWER_W-1:0] power;
    } cmd_t;

endpackage

`default_nettype wire
